/* common/cart_load_pkg.sv */
////////////////////////////////////////////////////////////
// Cartridge loader shared definitions
////////////////////////////////////////////////////////////
package cart_load_pkg;

	// Host and memory address widths
	localparam int DL_ADDR_W  = 25;
	localparam int MEM_ADDR_W = 24;

	// BIOS window starts at word 0x780000
	localparam logic [MEM_ADDR_W-1:0] BIOS_WORD_BASE = 24'h780000;

	// Region letter in the cartridge header
	localparam logic [DL_ADDR_W-1:0] HEADER_REGION_ADDR = 25'h1F0;

	// Byte address bits that make up the ROM size mask
	localparam int MASK_LSB = 13;
	localparam int MASK_MSB = 23;

	////////////////////////////////////////////////////////////
	// Types

	// One memory write, 40 bits
	typedef struct packed {
		logic [MEM_ADDR_W-1:0] addr;   // Word address
		logic [15:0]           data;
	} mem_wr_t;

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_e;

	// What the download index stands for
	typedef enum logic [1:0] {
		DL_BIOS  = 2'd0,
		DL_CART  = 2'd1,
		DL_OTHER = 2'd2
	} dl_kind_e;

	typedef enum logic [1:0] {
		WR_IDLE = 2'd0,
		WR_REQ  = 2'd1,
		WR_DONE = 2'd2
	} wr_state_e;

endpackage

/* loader/header_probe.sv */
////////////////////////////////////////////////////////////
// Cartridge header probe
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module header_probe
	import cart_load_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 load_wr,
	input  dl_kind_e             load_kind,
	input  logic [DL_ADDR_W-1:0] load_addr,
	input  logic [15:0]          load_data,
	output region_e              region,
	output logic [10:0]          rom_mask,
	output logic                 cart_mode
);

	logic is_cart;
	logic at_start;
	logic at_region;

	assign is_cart   = (load_kind == DL_CART);
	assign at_start  = (load_addr == '0);
	assign at_region = (load_addr == HEADER_REGION_ADDR);

	// Mode follows the last ROM write
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_mode <= 1'b0;
		end else if (load_wr) begin
			cart_mode <= is_cart;
		end
	end

	////////////////////////////////////////////////////////////
	// ROM size mask

	// A new image starts at byte 0, so the mask restarts there
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_mask <= '0;
		end else if (load_wr && is_cart) begin
			if (at_start) begin
				rom_mask <= '0;
			end else begin
				rom_mask <= rom_mask | load_addr[MASK_MSB:MASK_LSB];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Region letter

	// Low byte is the first character of the pair
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			region <= REGION_JP;
		end else if (load_wr && at_region) begin
			case (load_data[7:0])
				"J":     region <= REGION_JP;
				"U":     region <= REGION_US;
				default: region <= REGION_EU;   // E and anything unknown
			endcase
		end
	end

endmodule

/* loader/download_parser.sv */
////////////////////////////////////////////////////////////
// ROM download parser
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module download_parser
	import cart_load_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 dl_active,
	input  logic [7:0]           dl_index,
	input  logic                 dl_wr,
	input  logic [DL_ADDR_W-1:0] dl_addr,
	input  logic [15:0]          dl_data,
	output logic                 push,
	output mem_wr_t              push_data,
	output region_e              region,
	output logic [10:0]          rom_mask,
	output logic                 cart_mode
);

	dl_kind_e              kind;
	logic                  load_wr;
	logic [MEM_ADDR_W-1:0] word_addr;

	////////////////////////////////////////////////////////////
	// Index decode

	// Low six index bits of 0 or 1 mean a ROM image, bit 6 picks the cartridge
	always_comb begin
		if (dl_index[5:0] > 6'd1) begin
			kind = DL_OTHER;
		end else if (dl_index[6]) begin
			kind = DL_CART;
		end else begin
			kind = DL_BIOS;
		end
	end

	assign load_wr = dl_active & dl_wr & (kind != DL_OTHER);

	////////////////////////////////////////////////////////////
	// Address mapping

	always_comb begin
		if (kind == DL_CART) begin
			word_addr = {2'b00, dl_addr[22:1]};   // Low 8 MB
		end else begin
			word_addr = BIOS_WORD_BASE + {6'd0, dl_addr[18:1]};
		end
	end

	// One word in flight towards the FIFO
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			push <= 1'b0;
		end else begin
			push <= load_wr;
		end
	end

	// Payload only, qualified by push
	always_ff @(posedge clk_sys) begin
		if (load_wr) begin
			push_data.addr <= word_addr;
			push_data.data <= {dl_data[7:0], dl_data[15:8]};   // Host sends little endian
		end
	end

	////////////////////////////////////////////////////////////
	// Header watch

	header_probe u_header_probe (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.load_wr   (load_wr),
		.load_kind (kind),
		.load_addr (dl_addr),
		.load_data (dl_data),
		.region    (region),
		.rom_mask  (rom_mask),
		.cart_mode (cart_mode)
	);

endmodule

/* source/write_fifo.sv */
////////////////////////////////////////////////////////////
// Memory write FIFO
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module write_fifo
	import cart_load_pkg::*;
#(
	parameter int FIFO_DEPTH = 8   // Power of two, 4 or more
)
(
	input  logic    clk_sys,
	input  logic    reset,
	input  logic    push,
	input  mem_wr_t push_data,
	input  logic    pop,
	output mem_wr_t pop_data,
	output logic    empty,
	output logic    almost_full
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	mem_wr_t          mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;

	////////////////////////////////////////////////////////////
	// Storage

	always_ff @(posedge clk_sys) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	assign pop_data = mem[rd_ptr];   // Head shows without a read cycle

	////////////////////////////////////////////////////////////
	// Pointers and fill level

	// Pointers wrap on their own at a power of two
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			count <= '0;
		end else begin
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign empty = (count == '0);

	// Leaves room for the parser word already in flight
	assign almost_full = (count >= (PTR_W+1)'(FIFO_DEPTH - 1));

	////////////////////////////////////////////////////////////
	// Checks

	// Host must honour the wait line
	assert property (@(posedge clk_sys) disable iff (reset)
		push |-> (count != (PTR_W+1)'(FIFO_DEPTH)))
		else $error("write_fifo push while full");

	assert property (@(posedge clk_sys) disable iff (reset)
		pop |-> !empty)
		else $error("write_fifo pop while empty");

endmodule

/* source/mem_writer.sv */
////////////////////////////////////////////////////////////
// Memory write sequencer
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module mem_writer
	import cart_load_pkg::*;
(
	input  logic    clk_sys,
	input  logic    reset,
	input  logic    empty,
	input  mem_wr_t pop_data,
	input  logic    mem_ack,
	output logic    pop,
	output logic    mem_req,
	output mem_wr_t mem_wr
);

	wr_state_e state;
	mem_wr_t   hold;

	// Take the head only when no request is open
	assign pop = (state == WR_IDLE) && !empty;

	////////////////////////////////////////////////////////////
	// FSM

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= WR_IDLE;
		end else begin
			case (state)
				WR_IDLE: begin
					if (!empty) begin
						state <= WR_REQ;
					end
				end
				WR_REQ: begin
					if (mem_ack) begin
						state <= WR_DONE;
					end
				end
				WR_DONE: state <= WR_IDLE;   // Request low for a cycle
				default: state <= WR_IDLE;
			endcase
		end
	end

	// Holding register, stays put for the whole request
	always_ff @(posedge clk_sys) begin
		if (pop) begin
			hold <= pop_data;
		end
	end

	assign mem_req = (state == WR_REQ);
	assign mem_wr  = hold;

	////////////////////////////////////////////////////////////
	// Checks

	assert property (@(posedge clk_sys) disable iff (reset)
		(mem_req && !mem_ack) |=> $stable(mem_wr))
		else $error("mem_wr changed during an open request");

endmodule

/* source/cart_loader_top.sv */
////////////////////////////////////////////////////////////
// Cartridge loader top
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module cart_loader_top
	import cart_load_pkg::*;
#(
	parameter int FIFO_DEPTH = 8
)
(
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 dl_active,
	input  logic [7:0]           dl_index,
	input  logic                 dl_wr,
	input  logic [DL_ADDR_W-1:0] dl_addr,
	input  logic [15:0]          dl_data,
	output logic                 dl_wait,
	output logic                 mem_req,
	output mem_wr_t              mem_wr,
	input  logic                 mem_ack,
	output region_e              region,
	output logic [10:0]          rom_mask,
	output logic                 cart_mode
);

	logic    push;
	mem_wr_t push_data;
	logic    pop;
	mem_wr_t pop_data;
	logic    empty;

	// Host side
	download_parser u_parser (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_index  (dl_index),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.push      (push),
		.push_data (push_data),
		.region    (region),
		.rom_mask  (rom_mask),
		.cart_mode (cart_mode)
	);

	write_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.push        (push),
		.push_data   (push_data),
		.pop         (pop),
		.pop_data    (pop_data),
		.empty       (empty),
		.almost_full (dl_wait)   // Back-pressure straight to the host
	);

	// Memory side
	mem_writer u_writer (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.empty    (empty),
		.pop_data (pop_data),
		.mem_ack  (mem_ack),
		.pop      (pop),
		.mem_req  (mem_req),
		.mem_wr   (mem_wr)
	);

endmodule

/* sim/tb_mem_responder.sv */
////////////////////////////////////////////////////////////
// Memory responder model
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_mem_responder
	import cart_load_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       mem_req,
	input  mem_wr_t    mem_wr,
	input  logic [2:0] ack_delay,   // Fresh random value every cycle
	input  logic       slow,        // Always take the longest delay
	output logic       mem_ack
);

	mem_wr_t    log_q[$];   // Every write, in arrival order
	logic       busy;
	logic [2:0] left;
	logic [2:0] wait_now;

	// No acknowledge before the first clock
	initial mem_ack = 1'b0;

	// Delay is picked once, when a request first shows up
	always @(posedge clk_sys) begin
		if (reset) begin
			mem_ack <= 1'b0;
			busy    <= 1'b0;
			left    <= '0;
		end else if (mem_ack) begin
			mem_ack <= 1'b0;
			busy    <= 1'b0;
		end else if (mem_req) begin
			if (busy) begin
				wait_now = left;
			end else if (slow) begin
				wait_now = 3'd7;
			end else begin
				wait_now = ack_delay;
			end
			busy <= 1'b1;
			if (wait_now == 3'd0) begin
				mem_ack <= 1'b1;
				log_q.push_back(mem_wr);   // Write lands with the acknowledge
			end else begin
				left <= wait_now - 1'b1;
			end
		end
	end

endmodule

/* sim/cart_loader_tb.sv */
////////////////////////////////////////////////////////////
// Cartridge loader testbench
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module cart_loader_tb
	import cart_load_pkg::*;
();

	localparam int FIFO_DEPTH  = 8;
	localparam int N_CART      = 64;
	localparam int N_BIOS      = 32;
	localparam int N_SLOW      = 48;
	localparam int N_MASK      = 24;
	localparam int N_REGION    = 8;    // Words per region load
	localparam int N_IGNORED   = 16;
	localparam int TOTAL_WORDS = N_CART + N_BIOS + N_SLOW + N_MASK + 3 * N_REGION + N_IGNORED;
	localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 16 + 1000;

	logic                 clk_sys;
	logic                 reset;
	logic                 dl_active;
	logic [7:0]           dl_index;
	logic                 dl_wr;
	logic [DL_ADDR_W-1:0] dl_addr;
	logic [15:0]          dl_data;
	logic                 dl_wait;
	logic                 mem_req;
	mem_wr_t              mem_wr;
	logic                 mem_ack;
	region_e              region;
	logic [10:0]          rom_mask;
	logic                 cart_mode;
	logic                 slow;
	logic                 saw_wait;
	logic [2:0]           ack_delay  = '0;
	logic [31:0]          stim_lfsr  = 32'h3172;
	logic [31:0]          delay_lfsr = 32'h3172;

	// Reference model state
	mem_wr_t     exp_q[$];
	region_e     model_region = REGION_JP;
	logic [10:0] model_mask   = '0;
	logic        model_mode   = 1'b0;
	int          n_checked    = 0;

	cart_loader_top #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) UUT (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_index  (dl_index),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.dl_wait   (dl_wait),
		.mem_req   (mem_req),
		.mem_wr    (mem_wr),
		.mem_ack   (mem_ack),
		.region    (region),
		.rom_mask  (rom_mask),
		.cart_mode (cart_mode)
	);

	tb_mem_responder u_resp (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.mem_req   (mem_req),
		.mem_wr    (mem_wr),
		.ack_delay (ack_delay),
		.slow      (slow),
		.mem_ack   (mem_ack)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////
	// Random numbers

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = lfsr_next(stim_lfsr);
			value     = {value[30:0], stim_lfsr[0]};
		end
	endtask

	// Separate stream for acknowledge delays
	always @(negedge clk_sys) begin
		for (int i = 0; i < 3; i++) begin
			delay_lfsr = lfsr_next(delay_lfsr);
			ack_delay  = {ack_delay[1:0], delay_lfsr[0]};
		end
	end

	always @(posedge clk_sys) begin
		if (dl_wait) begin
			saw_wait <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks and model

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s expected %h got %h", name, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic check_status();
		check_value("region", model_region, region);
		check_value("rom_mask", model_mask, rom_mask);
		check_value("cart_mode", model_mode, cart_mode);
	endtask

	task automatic apply_model(input logic active, input logic [7:0] index,
		input logic [DL_ADDR_W-1:0] addr, input logic [15:0] data);
		mem_wr_t w;
		if (active && index[5:0] <= 6'd1) begin
			w.data = {data[7:0], data[15:8]};
			if (index[6]) begin
				w.addr = {2'b00, addr[22:1]};
				model_mask = (addr == '0) ? 11'd0 : (model_mask | addr[23:13]);
			end else begin
				w.addr = BIOS_WORD_BASE + addr[18:1];
			end
			model_mode = index[6];
			if (addr == HEADER_REGION_ADDR) begin
				if (data[7:0] == "J") begin
					model_region = REGION_JP;
				end else if (data[7:0] == "U") begin
					model_region = REGION_US;
				end else begin
					model_region = REGION_EU;
				end
			end
			exp_q.push_back(w);
		end
	endtask

	// Called on a falling edge, returns on one
	task automatic send_word(input logic active, input logic [7:0] index,
		input logic [DL_ADDR_W-1:0] addr, input logic [15:0] data);
		logic [31:0] gap;
		while (dl_wait) begin
			@(negedge clk_sys);
		end
		dl_active = active;
		dl_index  = index;
		dl_addr   = addr;
		dl_data   = data;
		dl_wr     = 1'b1;
		apply_model(active, index, addr, data);
		@(negedge clk_sys);
		dl_wr = 1'b0;
		rand_bits(2, gap);
		@(negedge clk_sys);   // Status settles one cycle after the write
		check_status();
		repeat (gap) @(negedge clk_sys);
	endtask

	task automatic drain_and_compare();
		mem_wr_t want;
		mem_wr_t got;
		while (u_resp.log_q.size() < exp_q.size()) begin
			@(negedge clk_sys);
		end
		repeat (20) @(negedge clk_sys);   // Room for any stray write
		check_value("write_count", exp_q.size(), u_resp.log_q.size());
		for (int i = n_checked; i < exp_q.size(); i++) begin
			want = exp_q[i];
			got  = u_resp.log_q[i];
			check_value("mem_wr.addr", want.addr, got.addr);
			check_value("mem_wr.data", want.data, got.data);
		end
		n_checked = exp_q.size();
		check_value("mem_req", 0, mem_req);
	endtask

	task automatic region_load(input logic [7:0] letter);
		logic [31:0] r;
		send_word(1'b1, 8'h40, '0, 16'h0000);
		for (int i = 1; i < N_REGION - 1; i++) begin
			rand_bits(16, r);
			send_word(1'b1, 8'h40, DL_ADDR_W'(i * 2), r[15:0]);
		end
		rand_bits(8, r);
		send_word(1'b1, 8'h40, HEADER_REGION_ADDR, {r[7:0], letter});
		drain_and_compare();
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [31:0]          r;
		logic [31:0]          step;
		logic [31:0]          top_addr;
		logic [DL_ADDR_W-1:0] addr;
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_index  = '0;
		dl_wr     = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		slow      = 1'b0;
		saw_wait  = 1'b0;
		repeat (16) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		check_value("mem_req", 0, mem_req);
		check_value("dl_wait", 0, dl_wait);
		check_status();

		// Cartridge from a random base
		rand_bits(23, r);
		addr = DL_ADDR_W'({r[22:1], 1'b0});
		for (int i = 0; i < N_CART; i++) begin
			rand_bits(16, r);
			send_word(1'b1, 8'h40, addr, r[15:0]);
			rand_bits(2, step);
			addr = addr + DL_ADDR_W'((step + 1) * 2);
		end
		drain_and_compare();
		check_value("cart_mode", 1, cart_mode);

		// BIOS, contiguous
		rand_bits(19, r);
		addr = DL_ADDR_W'({r[18:1], 1'b0});
		for (int i = 0; i < N_BIOS; i++) begin
			rand_bits(16, r);
			send_word(1'b1, 8'h00, addr + DL_ADDR_W'(i * 2), r[15:0]);
		end
		drain_and_compare();
		check_value("cart_mode", 0, cart_mode);

		// Slow memory fills the FIFO
		slow     = 1'b1;
		saw_wait = 1'b0;
		for (int i = 0; i < N_SLOW; i++) begin
			rand_bits(16, r);
			send_word(1'b1, 8'h41, DL_ADDR_W'(i * 2), r[15:0]);
		end
		drain_and_compare();
		check_value("dl_wait_seen", 1, saw_wait);
		slow = 1'b0;

		// ROM mask up to a random top address
		rand_bits(24, r);
		top_addr = {8'd0, r[23:1], 1'b0};
		send_word(1'b1, 8'h40, '0, 16'h0000);
		for (int i = 1; i < N_MASK - 1; i++) begin
			rand_bits(24, r);
			addr = DL_ADDR_W'((r[23:0] % (top_addr + 1)) & ~32'd1);
			send_word(1'b1, 8'h40, addr, r[15:0]);
		end
		send_word(1'b1, 8'h40, DL_ADDR_W'(top_addr), 16'h5a5a);
		drain_and_compare();

		// Japan last, so each letter moves the region away from the one before
		region_load("U");
		check_value("region", REGION_US, region);
		region_load("E");
		check_value("region", REGION_EU, region);
		region_load("J");
		check_value("region", REGION_JP, region);

		// Non-ROM index and inactive host, nothing may reach memory
		for (int i = 0; i < N_IGNORED; i++) begin
			rand_bits(16, r);
			if (i < N_IGNORED / 2) begin
				send_word(1'b1, 8'h05, DL_ADDR_W'(i * 2), r[15:0]);
			end else begin
				send_word(1'b0, 8'h40, DL_ADDR_W'(i * 2), r[15:0]);
			end
		end
		drain_and_compare();
		check_value("total_writes", TOTAL_WORDS - N_IGNORED, u_resp.log_q.size());

		$display("Result: PASSED");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired because memory writes stopped arriving");
		$display("Result: FAILED");
		$fatal(1, "Timeout");
	end

endmodule

/* cart_loader_top.f */
common/cart_load_pkg.sv
loader/header_probe.sv
loader/download_parser.sv
source/write_fifo.sv
source/mem_writer.sv
source/cart_loader_top.sv
sim/tb_mem_responder.sv
sim/cart_loader_tb.sv
